// File: common/ex_pkg.sv
package ex_pkg;

    localparam int WORD_W = 32;
    localparam int REG_W  = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_addr_t;
    typedef logic [4:0]        exc_code_t;
    typedef logic [3:0]        strb_t;
    typedef logic [1:0]        mem_size_t;

    // supplied by the decode stage
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_MULT,
        OP_MULTU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_CLZ,
        OP_CLO,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } ex_op_t;

    // MIPS exception codes
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_OV   = 5'd12;

    // access sizes on the data bus
    localparam mem_size_t MEM_BYTE = 2'd0;
    localparam mem_size_t MEM_HALF = 2'd1;
    localparam mem_size_t MEM_WORD = 2'd2;

    localparam int MUL_STAGES = 3;

    function automatic logic is_load(ex_op_t op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic is_store(ex_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

endpackage

// File: src/ex_alu.sv
`timescale 1ns/1ns

module ex_alu
    import ex_pkg::*;
(
    input  ex_op_t op_i,
    input  word_t  a_i,
    input  word_t  b_i,
    output word_t  result_o,
    output logic   overflow_o
);

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;
    assign shamt = a_i[4:0];

    // differing signs decide without the subtraction
    assign lt_signed   = (a_i[WORD_W-1] != b_i[WORD_W-1]) ? a_i[WORD_W-1] : diff[WORD_W-1];
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            OP_ADD, OP_ADDU: result_o = sum;
            OP_SUB, OP_SUBU: result_o = diff;
            OP_AND:          result_o = a_i & b_i;
            OP_OR:           result_o = a_i | b_i;
            OP_XOR:          result_o = a_i ^ b_i;
            OP_NOR:          result_o = ~(a_i | b_i);
            OP_SLT:          result_o = {{(WORD_W-1){1'b0}}, lt_signed};
            OP_SLTU:         result_o = {{(WORD_W-1){1'b0}}, lt_unsigned};
            OP_SLL:          result_o = b_i << shamt;
            OP_SRL:          result_o = b_i >> shamt;
            OP_SRA:          result_o = $signed(b_i) >>> shamt;
            default:         result_o = '0;
        endcase
    end

    // only the trapping forms report overflow
    always_comb begin
        case (op_i)
            OP_ADD: begin
                overflow_o = (a_i[WORD_W-1] == b_i[WORD_W-1])
                          && (sum[WORD_W-1] != a_i[WORD_W-1]);
            end
            OP_SUB: begin
                overflow_o = (a_i[WORD_W-1] != b_i[WORD_W-1])
                          && (diff[WORD_W-1] != a_i[WORD_W-1]);
            end
            default: overflow_o = 1'b0;
        endcase
    end

endmodule

// File: src/ex_hilo.sv
`timescale 1ns/1ns

module ex_hilo
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   issue_i,
    input  ex_op_t op_i,
    input  word_t  a_i,
    input  word_t  b_i,
    output word_t  hi_o,
    output word_t  lo_o,
    output logic   busy_o
);

    logic signed [WORD_W:0]     mul_a;
    logic signed [WORD_W:0]     mul_b;
    logic signed [2*WORD_W+1:0] full_prod;
    logic [2*WORD_W-1:0]        prod [MUL_STAGES-1];
    logic [MUL_STAGES-1:0]      hi_pend;
    logic [MUL_STAGES-1:0]      lo_pend;
    logic                       start_mul;
    logic                       wr_hi;
    logic                       wr_lo;

    assign start_mul = issue_i && (op_i == OP_MULT || op_i == OP_MULTU);
    assign wr_hi     = issue_i && op_i == OP_MTHI;
    assign wr_lo     = issue_i && op_i == OP_MTLO;

    // operands get one extra bit, sign or zero
    always_ff @(posedge clk) begin
        if (start_mul) begin
            mul_a <= {op_i == OP_MULT && a_i[WORD_W-1], a_i};
            mul_b <= {op_i == OP_MULT && b_i[WORD_W-1], b_i};
        end
    end

    assign full_prod = mul_a * mul_b;

    always_ff @(posedge clk) begin
        prod[0] <= full_prod[2*WORD_W-1:0];
        for (int i = 1; i < MUL_STAGES - 1; i++) begin
            prod[i] <= prod[i-1];
        end
    end

    // an MTHI/MTLO cancels older products for its register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            hi_pend <= '0;
            lo_pend <= '0;
        end else begin
            hi_pend <= {hi_pend[MUL_STAGES-2:0], start_mul} & ~{MUL_STAGES{wr_hi}};
            lo_pend <= {lo_pend[MUL_STAGES-2:0], start_mul} & ~{MUL_STAGES{wr_lo}};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hi) begin
            hi_o <= a_i;
        end else if (hi_pend[MUL_STAGES-1]) begin
            hi_o <= prod[MUL_STAGES-2][2*WORD_W-1:WORD_W];
        end
        if (wr_lo) begin
            lo_o <= a_i;
        end else if (lo_pend[MUL_STAGES-1]) begin
            lo_o <= prod[MUL_STAGES-2][WORD_W-1:0];
        end
    end

    assign busy_o = |(hi_pend | lo_pend);

endmodule

// File: src/ex_count_lead.sv
`timescale 1ns/1ns

module ex_count_lead
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   issue_i,
    input  ex_op_t op_i,
    input  word_t  a_i,
    input  logic   accept_i,
    output word_t  count_o,
    output logic   finished_o
);

    logic       running;
    logic       start;
    word_t      shreg;
    logic [5:0] cnt;

    assign start = issue_i && (op_i == OP_CLZ || op_i == OP_CLO) && !running && !finished_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            running    <= 1'b0;
            finished_o <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
        end else if (running && !shreg[WORD_W-1]) begin
            running    <= 1'b0;
            finished_o <= 1'b1;
        end else if (accept_i) begin
            finished_o <= 1'b0;
        end
    end

    // clz counts ones of the inverted operand
    always_ff @(posedge clk) begin
        if (start) begin
            shreg <= (op_i == OP_CLZ) ? ~a_i : a_i;
            cnt   <= '0;
        end else if (running && shreg[WORD_W-1]) begin
            shreg <= shreg << 1;
            cnt   <= cnt + 6'd1;
        end
    end

    assign count_o = {{(WORD_W-6){1'b0}}, cnt};

endmodule

// File: src/ex_mem_req.sv
`timescale 1ns/1ns

module ex_mem_req
    import ex_pkg::*;
(
    input  logic        issue_i,
    input  ex_op_t      op_i,
    input  word_t       a_i,
    input  word_t       b_i,
    input  logic [15:0] imm_i,
    output word_t       eaddr_o,
    output logic        addr_err_o,
    output logic        data_req_o,
    output logic        data_wr_o,
    output word_t       data_addr_o,
    output mem_size_t   data_size_o,
    output strb_t       data_wstrb_o,
    output word_t       data_wdata_o
);

    logic [1:0] offset;
    logic       half_op;
    logic       word_op;
    logic       mem_op;

    assign eaddr_o = a_i + {{(WORD_W-16){imm_i[15]}}, imm_i};
    assign offset  = eaddr_o[1:0];

    assign half_op = op_i inside {OP_LH, OP_LHU, OP_SH};
    assign word_op = op_i inside {OP_LW, OP_SW};
    assign mem_op  = is_load(op_i) || is_store(op_i);

    // byte accesses are never misaligned
    assign addr_err_o = (half_op && offset[0]) || (word_op && offset != 2'b00);

    assign data_req_o  = issue_i && mem_op && !addr_err_o;
    assign data_wr_o   = is_store(op_i);
    assign data_addr_o = {eaddr_o[WORD_W-1:2], 2'b00};

    always_comb begin
        data_size_o  = MEM_WORD;
        data_wstrb_o = '0;
        data_wdata_o = b_i;
        case (op_i)
            OP_LB, OP_LBU: begin
                data_size_o = MEM_BYTE;
            end
            OP_LH, OP_LHU: begin
                data_size_o = MEM_HALF;
            end
            OP_SB: begin
                data_size_o  = MEM_BYTE;
                data_wstrb_o = 4'b0001 << offset;
                data_wdata_o = {4{b_i[7:0]}};
            end
            OP_SH: begin
                data_size_o  = MEM_HALF;
                data_wstrb_o = 4'b0011 << offset;
                data_wdata_o = {2{b_i[15:0]}};
            end
            OP_SW: begin
                data_wstrb_o = 4'b1111;
            end
            default: begin
                data_wstrb_o = '0;
            end
        endcase
    end

endmodule

// File: src/ex_retire.sv
`timescale 1ns/1ns

module ex_retire
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid_i,
    input  ex_op_t    op_i,
    input  reg_addr_t waddr_i,
    input  word_t     b_i,
    input  word_t     alu_result_i,
    input  logic      overflow_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    input  logic      hilo_busy_i,
    input  word_t     count_i,
    input  logic      count_done_i,
    input  word_t     eaddr_i,
    input  logic      addr_err_i,
    input  logic      data_addr_ok_i,
    input  logic      ready_i,
    output logic      issue_o,
    output logic      accept_o,
    output logic      done_o,
    output logic      commit_o,
    output exc_code_t exc_code_o,
    output logic      valid_o,
    output word_t     result_o,
    output reg_addr_t waddr_o
);

    logic  done_lat;
    logic  exc;
    logic  op_done;
    logic  writes_rd;
    word_t result;

    // done but waiting on the next stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done_lat <= 1'b0;
        end else if (ready_i) begin
            done_lat <= 1'b0;
        end else if (valid_i && done_o) begin
            done_lat <= 1'b1;
        end
    end

    assign issue_o  = valid_i && !done_lat;
    assign exc      = overflow_i || addr_err_i;
    assign commit_o = issue_o && exc;

    always_comb begin
        if (addr_err_i) begin
            exc_code_o = is_store(op_i) ? EXC_ADES : EXC_ADEL;
        end else begin
            exc_code_o = EXC_OV;
        end
    end

    always_comb begin
        case (op_i)
            OP_MFHI, OP_MFLO: op_done = !hilo_busy_i;
            OP_CLZ, OP_CLO:   op_done = count_done_i;
            default:          op_done = !(is_load(op_i) || is_store(op_i)) || data_addr_ok_i;
        endcase
        if (exc) begin
            op_done = 1'b1;
        end
    end

    assign done_o   = valid_i && (done_lat || op_done);
    assign accept_o = done_o && ready_i;

    always_comb begin
        case (op_i)
            OP_MFHI:        result = hi_i;
            OP_MFLO:        result = lo_i;
            OP_CLZ, OP_CLO: result = count_i;
            OP_LUI:         result = {b_i[15:0], 16'h0000};
            default:        result = is_load(op_i) ? eaddr_i : alu_result_i;
        endcase
    end

    // stores and hi/lo writers have no register result
    assign writes_rd = !(is_store(op_i)
                      || op_i inside {OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO});

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_o <= 1'b0;
        end else if (ready_i) begin
            valid_o <= valid_i && done_o && !exc && writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_i) begin
            result_o <= result;
            waddr_o  <= waddr_i;
        end
    end

endmodule

// File: src/ex_top.sv
`timescale 1ns/1ns

module ex_top
    import ex_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,

    // from the decode stage
    input  logic        valid_i,
    input  ex_op_t      op_i,
    input  word_t       a_i,
    input  word_t       b_i,
    input  logic [15:0] imm_i,
    input  reg_addr_t   waddr_i,
    output logic        done_o,

    // to the next stage
    input  logic        ready_i,
    output logic        valid_o,
    output word_t       result_o,
    output reg_addr_t   waddr_o,

    // data bus
    output logic        data_req_o,
    output logic        data_wr_o,
    output word_t       data_addr_o,
    output mem_size_t   data_size_o,
    output strb_t       data_wstrb_o,
    output word_t       data_wdata_o,
    input  logic        data_addr_ok_i,

    output logic        commit_o,
    output exc_code_t   exc_code_o
);

    logic  issue;
    logic  accept;
    word_t alu_result;
    logic  overflow;
    word_t hi;
    word_t lo;
    logic  hilo_busy;
    word_t count;
    logic  count_done;
    word_t eaddr;
    logic  addr_err;

    ex_alu u_alu (
        .op_i       (op_i),
        .a_i        (a_i),
        .b_i        (b_i),
        .result_o   (alu_result),
        .overflow_o (overflow)
    );

    ex_hilo u_hilo (
        .clk     (clk),
        .resetn  (resetn),
        .issue_i (issue),
        .op_i    (op_i),
        .a_i     (a_i),
        .b_i     (b_i),
        .hi_o    (hi),
        .lo_o    (lo),
        .busy_o  (hilo_busy)
    );

    ex_count_lead u_count_lead (
        .clk        (clk),
        .resetn     (resetn),
        .issue_i    (issue),
        .op_i       (op_i),
        .a_i        (a_i),
        .accept_i   (accept),
        .count_o    (count),
        .finished_o (count_done)
    );

    ex_mem_req u_mem_req (
        .issue_i      (issue),
        .op_i         (op_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .imm_i        (imm_i),
        .eaddr_o      (eaddr),
        .addr_err_o   (addr_err),
        .data_req_o   (data_req_o),
        .data_wr_o    (data_wr_o),
        .data_addr_o  (data_addr_o),
        .data_size_o  (data_size_o),
        .data_wstrb_o (data_wstrb_o),
        .data_wdata_o (data_wdata_o)
    );

    ex_retire u_retire (
        .clk            (clk),
        .resetn         (resetn),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .waddr_i        (waddr_i),
        .b_i            (b_i),
        .alu_result_i   (alu_result),
        .overflow_i     (overflow),
        .hi_i           (hi),
        .lo_i           (lo),
        .hilo_busy_i    (hilo_busy),
        .count_i        (count),
        .count_done_i   (count_done),
        .eaddr_i        (eaddr),
        .addr_err_i     (addr_err),
        .data_addr_ok_i (data_addr_ok_i),
        .ready_i        (ready_i),
        .issue_o        (issue),
        .accept_o       (accept),
        .done_o         (done_o),
        .commit_o       (commit_o),
        .exc_code_o     (exc_code_o),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .waddr_o        (waddr_o)
    );

endmodule

// File: bench/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

function automatic logic load_op(ex_op_t op);
    return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
endfunction

function automatic logic store_op(ex_op_t op);
    return op inside {OP_SB, OP_SH, OP_SW};
endfunction

function automatic logic writes_result(ex_op_t op);
    return !(store_op(op) || op inside {OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO});
endfunction

function automatic word_t eff_addr(word_t a, logic [15:0] imm);
    return a + {{16{imm[15]}}, imm};
endfunction

// zero when the instruction raises nothing
function automatic exc_code_t exc_of(ex_op_t op, word_t a, word_t b, logic [15:0] imm);
    word_t       ea;
    logic [32:0] wide;
    ea   = eff_addr(a, imm);
    wide = (op == OP_ADD) ? {a[31], a} + {b[31], b} : {a[31], a} - {b[31], b};
    if ((op inside {OP_LH, OP_LHU, OP_SH} && ea[0])
            || (op inside {OP_LW, OP_SW} && ea[1:0] != 2'b00)) begin
        return store_op(op) ? EXC_ADES : EXC_ADEL;
    end
    // a carry into the extra sign bit that disagrees means overflow
    if (op inside {OP_ADD, OP_SUB} && wide[32] != wide[31]) begin
        return EXC_OV;
    end
    return '0;
endfunction

function automatic word_t lead_count(ex_op_t op, word_t a);
    word_t n;
    logic  lead;
    lead = (op == OP_CLO);
    n    = '0;
    for (int i = 31; i >= 0; i--) begin
        if (a[i] != lead) begin
            break;
        end
        n++;
    end
    return n;
endfunction

function automatic word_t result_of(ex_op_t op, word_t a, word_t b, logic [15:0] imm,
                                    word_t hi, word_t lo);
    case (op)
        OP_ADD, OP_ADDU: return a + b;
        OP_SUB, OP_SUBU: return a - b;
        OP_AND:          return a & b;
        OP_OR:           return a | b;
        OP_XOR:          return a ^ b;
        OP_NOR:          return ~(a | b);
        OP_SLT:          return ($signed(a) < $signed(b)) ? 1 : 0;
        OP_SLTU:         return (a < b) ? 1 : 0;
        OP_SLL:          return b << a[4:0];
        OP_SRL:          return b >> a[4:0];
        OP_SRA:          return $signed(b) >>> a[4:0];
        OP_LUI:          return {b[15:0], 16'h0000};
        OP_MFHI:         return hi;
        OP_MFLO:         return lo;
        OP_CLZ, OP_CLO:  return lead_count(op, a);
        default:         return eff_addr(a, imm);
    endcase
endfunction

function automatic logic [63:0] product_of(ex_op_t op, word_t a, word_t b);
    if (op == OP_MULT) begin
        return {{32{a[31]}}, a} * {{32{b[31]}}, b};
    end
    return {32'h0, a} * {32'h0, b};
endfunction

function automatic mem_size_t size_of(ex_op_t op);
    if (op inside {OP_LB, OP_LBU, OP_SB}) begin
        return MEM_BYTE;
    end
    return (op inside {OP_LH, OP_LHU, OP_SH}) ? MEM_HALF : MEM_WORD;
endfunction

function automatic strb_t strb_of(ex_op_t op, word_t ea);
    strb_t s;
    s = 4'b0000;
    for (int i = 0; i < 4; i++) begin
        if (op == OP_SW || (op == OP_SB && i == int'(ea[1:0]))
                || (op == OP_SH && i / 2 == int'(ea[1]))) begin
            s[i] = 1'b1;
        end
    end
    return s;
endfunction

function automatic word_t wdata_of(ex_op_t op, word_t b);
    case (op)
        OP_SB:   return {b[7:0], b[7:0], b[7:0], b[7:0]};
        OP_SH:   return {b[15:0], b[15:0]};
        default: return b;
    endcase
endfunction

`endif

// File: bench/tb_ex_top.sv
`timescale 1ns/1ns

module tb_ex_top
    import ex_pkg::*;
();

    localparam int N_INSTR    = 400;
    localparam int CYCLES_PER = 60;
    localparam int CLK_PERIOD = 20;

    logic        clk;
    logic        resetn;
    logic        valid_i;
    ex_op_t      op_i;
    word_t       a_i;
    word_t       b_i;
    logic [15:0] imm_i;
    reg_addr_t   waddr_i;
    logic        done_o;
    logic        ready_i;
    logic        valid_o;
    word_t       result_o;
    reg_addr_t   waddr_o;
    logic        data_req_o;
    logic        data_wr_o;
    word_t       data_addr_o;
    mem_size_t   data_size_o;
    strb_t       data_wstrb_o;
    word_t       data_wdata_o;
    logic        data_addr_ok_i;
    logic        commit_o;
    exc_code_t   exc_code_o;

    logic [31:0] seed;
    word_t       model_hi;
    word_t       model_lo;
    logic [36:0] expect_q [$];
    exc_code_t   exp_exc;
    logic        mem_ok;
    logic        instant;
    logic        first_cycle;
    int          hs_count;
    int          commit_seen;

    `include "ex_model.svh"

    ex_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // low LCG bits are weak, so only the upper halves are used
    function automatic word_t rand_word();
        logic [31:0] h;
        logic [31:0] l;
        h = lcg_next();
        l = lcg_next();
        return {h[31:16], l[31:16]};
    endfunction

    // corner values show up often, for overflow and clz/clo
    function automatic word_t pick_operand();
        logic [31:0] r;
        r = lcg_next();
        case (r[18:16])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h7fff_ffff;
            3'd4:    return rand_word() >> r[28:24];
            3'd5:    return ~(rand_word() >> r[28:24]);
            default: return rand_word();
        endcase
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic value_error(string name, word_t got, word_t exp);
        fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic pick_instr(int n);
        logic [31:0] r;
        logic [31:0] r2;
        r  = lcg_next();
        r2 = lcg_next();
        // hi/lo get known values before anything reads them
        case (n)
            0:       op_i = OP_MTHI;
            1:       op_i = OP_MTLO;
            default: op_i = (r[27:26] == 2'b00) ? ex_op_t'(5'(15 + r[18:16] % 3'd6))
                                                 : ex_op_t'(5'(r[23:16] % 8'd31));
        endcase
        a_i     = pick_operand();
        b_i     = pick_operand();
        imm_i   = r2[31:16];
        waddr_i = r[31:27];
        // aligned about half the time
        if (load_op(op_i) || store_op(op_i)) begin
            a_i[1:0]   = 2'b00;
            imm_i[1:0] = r2[14] ? r2[13:12] : 2'b00;
        end
        valid_i     = 1'b1;
        exp_exc     = exc_of(op_i, a_i, b_i, imm_i);
        mem_ok      = (load_op(op_i) || store_op(op_i)) && exp_exc == '0;
        instant     = exp_exc != '0 || !(load_op(op_i) || store_op(op_i)
                      || op_i inside {OP_CLZ, OP_CLO, OP_MFHI, OP_MFLO});
        hs_count    = 0;
        commit_seen = 0;
        first_cycle = 1'b1;
    endtask

    // downstream takes the output register at edges with ready_i high
    task automatic check_outputs();
        logic [36:0] item;
        if (valid_o && ready_i) begin
            assert (expect_q.size() > 0)
                else fail_run("valid_o was raised while no result was expected");
            item = expect_q.pop_front();
            assert (result_o === item[31:0]) else value_error("result_o", result_o, item[31:0]);
            assert (waddr_o === item[36:32])
                else value_error("waddr_o", 32'(waddr_o), 32'(item[36:32]));
        end
    endtask

    task automatic check_current();
        word_t ea;
        logic  exp_req;
        ea      = eff_addr(a_i, imm_i);
        exp_req = mem_ok && hs_count == 0;
        if (commit_o) begin
            assert (exp_exc != '0) else fail_run("commit_o was raised with no exception due");
            assert (commit_seen == 0) else fail_run("commit_o was raised twice for one instruction");
            assert (exc_code_o == exp_exc)
                else value_error("exc_code_o", 32'(exc_code_o), 32'(exp_exc));
            commit_seen++;
        end
        assert (data_req_o === exp_req)
            else value_error("data_req_o", 32'(data_req_o), 32'(exp_req));
        if (data_req_o) begin
            assert (data_addr_o == {ea[31:2], 2'b00})
                else value_error("data_addr_o", data_addr_o, {ea[31:2], 2'b00});
            assert (data_wr_o == store_op(op_i))
                else value_error("data_wr_o", 32'(data_wr_o), 32'(store_op(op_i)));
            assert (data_size_o == size_of(op_i))
                else value_error("data_size_o", 32'(data_size_o), 32'(size_of(op_i)));
            assert (data_wstrb_o == strb_of(op_i, ea))
                else value_error("data_wstrb_o", 32'(data_wstrb_o), 32'(strb_of(op_i, ea)));
            if (store_op(op_i)) begin
                assert (data_wdata_o == wdata_of(op_i, b_i))
                    else value_error("data_wdata_o", data_wdata_o, wdata_of(op_i, b_i));
            end
            if (data_addr_ok_i) begin
                hs_count++;
            end
        end
        if (first_cycle && instant) begin
            assert (done_o === 1'b1) else value_error("done_o", 32'(done_o), 32'd1);
        end
        first_cycle = 1'b0;
    endtask

    task automatic retire_model();
        assert (hs_count == (mem_ok ? 1 : 0))
            else fail_run("a memory operation did not see exactly one address handshake");
        assert (commit_seen == ((exp_exc != '0) ? 1 : 0))
            else fail_run("commit_o did not pulse once for an instruction with an exception");
        if (exp_exc == '0) begin
            if (writes_result(op_i)) begin
                expect_q.push_back({waddr_i, result_of(op_i, a_i, b_i, imm_i, model_hi, model_lo)});
            end
            case (op_i)
                OP_MULT, OP_MULTU: {model_hi, model_lo} = product_of(op_i, a_i, b_i);
                OP_MTHI:           model_hi = a_i;
                OP_MTLO:           model_lo = a_i;
                default:           ;
            endcase
        end
    endtask

    // one clock cycle, entered 2 ns after a rising edge
    task automatic step_cycle(output logic accepted);
        logic [31:0] r;
        r              = lcg_next();
        ready_i        = r[20:19] != 2'b00;
        data_addr_ok_i = 1'b0;
        #1;
        // memory answers only while a request is pending
        r              = lcg_next();
        data_addr_ok_i = data_req_o && r[22:21] == 2'b00;
        @(negedge clk);
        check_outputs();
        check_current();
        accepted = done_o && ready_i;
        if (accepted) begin
            retire_model();
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        logic accepted;
        seed           = 32'd36934;
        resetn         = 1'b0;
        valid_i        = 1'b0;
        op_i           = OP_NOP;
        a_i            = '0;
        b_i            = '0;
        imm_i          = '0;
        waddr_i        = '0;
        ready_i        = 1'b0;
        data_addr_ok_i = 1'b0;
        model_hi       = '0;
        model_lo       = '0;
        exp_exc        = '0;
        mem_ok         = 1'b0;
        instant        = 1'b0;
        first_cycle    = 1'b0;
        hs_count       = 0;
        commit_seen    = 0;
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;
        for (int n = 0; n < N_INSTR; n++) begin
            pick_instr(n);
            accepted = 1'b0;
            while (!accepted) begin
                step_cycle(accepted);
            end
        end
        // let the last result leave the output register
        valid_i     = 1'b0;
        op_i        = OP_NOP;
        exp_exc     = '0;
        mem_ok      = 1'b0;
        first_cycle = 1'b0;
        repeat (20) begin
            step_cycle(accepted);
        end
        if (expect_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run($sformatf("%0d expected results never appeared on valid_o", expect_q.size()));
        end
    end

    initial begin
        #(N_INSTR * CYCLES_PER * CLK_PERIOD);
        fail_run("Timeout: the stage stopped making progress before all instructions retired");
    end

endmodule

// File: tb.f
+incdir+bench
common/ex_pkg.sv
src/ex_alu.sv
src/ex_hilo.sv
src/ex_count_lead.sv
src/ex_mem_req.sv
src/ex_retire.sv
src/ex_top.sv
bench/tb_ex_top.sv
